// File: src/cpu_pkg.sv
package cpu_pkg;

typedef logic [31:0] uint32_t;
typedef logic [4:0]  reg_addr_t;
typedef logic [7:0]  asid_t;
typedef logic [18:0] vpn2_t;
typedef logic [23:0] pfn_t;
typedef logic [4:0]  exc_code_t;

localparam exc_code_t EXCCODE_INT  = 5'd0;
localparam exc_code_t EXCCODE_TLBL = 5'd2;
localparam exc_code_t EXCCODE_TLBS = 5'd3;
localparam exc_code_t EXCCODE_ADEL = 5'd4;
localparam exc_code_t EXCCODE_ADES = 5'd5;

// cache geometry, reported through config1 only
localparam int ICACHE_SETS_LOG = 7;
localparam int ICACHE_LINE_LOG = 5;
localparam int ICACHE_WAYS     = 2;
localparam int DCACHE_SETS_LOG = 7;
localparam int DCACHE_LINE_LOG = 5;
localparam int DCACHE_WAYS     = 2;

localparam uint32_t PRID_VALUE = 32'h0001_8000;

typedef struct packed {
	logic      we;
	logic [2:0] wsel;
	reg_addr_t waddr;
	uint32_t   wdata;
} cp0_req_t;

typedef struct packed {
	logic      valid;
	logic      eret;
	logic      delayslot;
	exc_code_t code;
	uint32_t   pc;
	uint32_t   extra;
} except_req_t;

typedef struct packed {
	vpn2_t      vpn2;
	asid_t      asid;
	pfn_t       pfn0;
	logic [2:0] c0;
	logic       d0;
	logic       v0;
	pfn_t       pfn1;
	logic [2:0] c1;
	logic       d1;
	logic       v1;
	logic       G;
} tlb_entry_t;

typedef enum logic [1:0] {
	TLB_OP_P,
	TLB_OP_R,
	TLB_OP_WI,
	TLB_OP_WR
} tlb_op_t;

typedef struct packed {
	logic [2:0] zero31;
	logic       cu0;
	logic [4:0] zero27;
	logic       bev;
	logic [5:0] zero21;
	logic [7:0] im;
	logic [2:0] zero7;
	logic       um;
	logic       zero3;
	logic       erl;
	logic       exl;
	logic       ie;
} status_t;

typedef struct packed {
	logic       bd;
	logic [14:0] zero30;
	logic [7:0] ip;
	logic       zero7;
	exc_code_t  exc_code;
	logic [1:0] zero1;
} cause_t;

// select 0 registers by number, then the select 1 ones
typedef struct packed {
	uint32_t index;
	uint32_t random;
	uint32_t entry_lo0;
	uint32_t entry_lo1;
	uint32_t context_reg;
	uint32_t page_mask;
	uint32_t wired;
	uint32_t hwrena;
	uint32_t bad_vaddr;
	uint32_t count;
	uint32_t entry_hi;
	uint32_t compare;
	status_t status;
	cause_t  cause;
	uint32_t epc;
	uint32_t prid;
	uint32_t config0;
	uint32_t lladdr;
	uint32_t watch_lo;
	uint32_t watch_hi;
	uint32_t xcontext;
	uint32_t reg21;
	uint32_t reg22;
	uint32_t debug;
	uint32_t depc;
	uint32_t perf_cnt;
	uint32_t err_ctl;
	uint32_t cache_err;
	uint32_t tag_lo;
	uint32_t tag_hi;
	uint32_t error_epc;
	uint32_t desave;
	uint32_t ebase;
	uint32_t config1;
} cp0_regs_t;

endpackage

// File: src/cp0_write_mask.sv
`timescale 1ns/1ps

module cp0_write_mask #(
	parameter int TLB_ENTRIES = 16
) (
	input  logic [2:0]         wsel,
	input  cpu_pkg::reg_addr_t waddr,
	output cpu_pkg::uint32_t   mask
);

import cpu_pkg::*;

localparam int IDX_W = $clog2(TLB_ENTRIES);
localparam uint32_t LOW_MASK = (32'd1 << IDX_W) - 32'd1;

always_comb begin
	mask = '0;
	// select 1 registers are handled in cp0
	if (wsel == 3'd0) begin
		case (waddr)
			5'd0:               mask = LOW_MASK;
			5'd2, 5'd3:         mask = 32'h3fff_ffff;
			5'd4:               mask = 32'hff80_0000;
			5'd6:               mask = LOW_MASK;
			5'd9, 5'd11, 5'd14: mask = 32'hffff_ffff;
			// vpn2 and asid
			5'd10:              mask = 32'hffff_e0ff;
			5'd12:              mask = 32'h1040_ff17;
			// software interrupt bits
			5'd13:              mask = 32'h0000_0300;
			5'd16:              mask = 32'h0000_0007;
			default:            mask = '0;
		endcase
	end
end

endmodule

// File: src/cp0.sv
`timescale 1ns/1ps

module cp0 #(
	parameter int TLB_ENTRIES = 16,
	parameter bit FULL_CP0    = 1'b1
) (
	input  logic                           clk,
	input  logic                           rst,
	input  cpu_pkg::reg_addr_t             raddr,
	input  logic [2:0]                     rsel,
	input  cpu_pkg::cp0_req_t              wreq,
	input  cpu_pkg::except_req_t           except_req,
	input  logic                           tlbp_req,
	input  cpu_pkg::uint32_t               tlbp_res,
	input  logic                           tlbr_req,
	input  cpu_pkg::tlb_entry_t            tlbr_res,
	input  logic                           tlbwr_req,
	output cpu_pkg::uint32_t               rdata,
	output cpu_pkg::tlb_entry_t            tlb_wdata,
	output logic [$clog2(TLB_ENTRIES)-1:0] tlb_index,
	output logic [$clog2(TLB_ENTRIES)-1:0] tlb_random,
	output cpu_pkg::asid_t                 asid,
	output logic                           user_mode,
	output logic                           kseg0_uncached,
	output logic                           timer_int
);

import cpu_pkg::*;

localparam int IDX_W    = $clog2(TLB_ENTRIES);
localparam int TOP_WORD = $bits(cp0_regs_t) / 32 - 1;
localparam uint32_t RANDOM_TOP = uint32_t'(TLB_ENTRIES - 1);

localparam logic [2:0] IC_SETS = 3'(ICACHE_SETS_LOG - 6);
localparam logic [2:0] IC_LINE = 3'(ICACHE_LINE_LOG - 1);
localparam logic [2:0] IC_WAYS = 3'(ICACHE_WAYS - 1);
localparam logic [2:0] DC_SETS = 3'(DCACHE_SETS_LOG - 6);
localparam logic [2:0] DC_LINE = 3'(DCACHE_LINE_LOG - 1);
localparam logic [2:0] DC_WAYS = 3'(DCACHE_WAYS - 1);

// M flags config1, standard TLB, kseg0 cacheable
localparam uint32_t CONFIG0_RST = {FULL_CP0, 21'd0, 3'd1, 4'd0, 3'd3};
localparam uint32_t CONFIG1_RST = {1'b0, 6'(TLB_ENTRIES - 1), IC_SETS, IC_LINE, IC_WAYS,
	DC_SETS, DC_LINE, DC_WAYS, 7'd0};
localparam uint32_t STATUS_RST = 32'h0040_0000;
localparam uint32_t EBASE_RST  = 32'h8000_0000;

cp0_regs_t regs_q;
cp0_regs_t regs_d;
uint32_t   wmask;
uint32_t   wr_word;
int        rd_base;
int        wr_base;
logic      compare_wr;

assign rd_base    = (TOP_WORD - int'(raddr)) * 32;
assign wr_base    = (TOP_WORD - int'(wreq.waddr)) * 32;
assign compare_wr = wreq.we && wreq.wsel == 3'd0 && wreq.waddr == 5'd11;

assign asid           = regs_q.entry_hi[7:0];
assign user_mode      = regs_q.status.um && !regs_q.status.erl && !regs_q.status.exl;
assign kseg0_uncached = regs_q.config0[2:0] == 3'd2;
assign tlb_index      = regs_q.index[IDX_W-1:0];
assign tlb_random     = regs_q.random[IDX_W-1:0];

assign tlb_wdata.vpn2 = regs_q.entry_hi[31:13];
assign tlb_wdata.asid = regs_q.entry_hi[7:0];
assign tlb_wdata.pfn0 = regs_q.entry_lo0[29:6];
assign tlb_wdata.c0   = regs_q.entry_lo0[5:3];
assign tlb_wdata.d0   = regs_q.entry_lo0[2];
assign tlb_wdata.v0   = regs_q.entry_lo0[1];
assign tlb_wdata.pfn1 = regs_q.entry_lo1[29:6];
assign tlb_wdata.c1   = regs_q.entry_lo1[5:3];
assign tlb_wdata.d1   = regs_q.entry_lo1[2];
assign tlb_wdata.v1   = regs_q.entry_lo1[1];
// global only when both halves say so
assign tlb_wdata.G    = regs_q.entry_lo0[0] & regs_q.entry_lo1[0];

always_comb begin
	rdata = '0;
	if (rsel == 3'd0) begin
		rdata = regs_q[rd_base +: 32];
	end else if (FULL_CP0 && rsel == 3'd1) begin
		if (raddr == 5'd15)
			rdata = regs_q.ebase;
		else if (raddr == 5'd16)
			rdata = regs_q.config1;
	end
end

cp0_write_mask #(
	.TLB_ENTRIES(TLB_ENTRIES)
) u_write_mask (
	.wsel (wreq.wsel),
	.waddr(wreq.waddr),
	.mask (wmask)
);

always_ff @(posedge clk) begin
	if (rst) begin
		regs_q         <= '0;
		regs_q.random  <= RANDOM_TOP;
		regs_q.status  <= STATUS_RST;
		regs_q.prid    <= PRID_VALUE;
		regs_q.config0 <= CONFIG0_RST;
		regs_q.ebase   <= EBASE_RST;
		regs_q.config1 <= CONFIG1_RST;
	end else begin
		regs_q <= regs_d;
	end
end

always_ff @(posedge clk) begin
	if (rst)
		timer_int <= 1'b0;
	else if (compare_wr)
		timer_int <= 1'b0;
	else if (regs_q.compare != '0 && regs_q.compare == regs_q.count)
		timer_int <= 1'b1;
end

always_comb begin
	regs_d       = regs_q;
	regs_d.count = regs_q.count + 32'd1;

	// random counts down towards wired, then wraps to the top
	if (tlbwr_req) begin
		if (regs_q.random[IDX_W-1:0] == regs_q.wired[IDX_W-1:0])
			regs_d.random = RANDOM_TOP;
		else
			regs_d.random = regs_q.random - 32'd1;
	end

	wr_word = regs_d[wr_base +: 32];
	if (wreq.we && wreq.wsel == 3'd0) begin
		regs_d[wr_base +: 32] = (wreq.wdata & wmask) | (wr_word & ~wmask);
		if (wreq.waddr == 5'd6)
			regs_d.random = RANDOM_TOP;
	end
	if (FULL_CP0 && wreq.we && wreq.wsel == 3'd1 && wreq.waddr == 5'd15)
		regs_d.ebase[29:12] = wreq.wdata[29:12];

	if (tlbr_req) begin
		regs_d.entry_hi[31:13] = tlbr_res.vpn2;
		regs_d.entry_hi[7:0]   = tlbr_res.asid;
		regs_d.entry_lo0 = {2'b0, tlbr_res.pfn0, tlbr_res.c0, tlbr_res.d0, tlbr_res.v0,
			tlbr_res.G};
		regs_d.entry_lo1 = {2'b0, tlbr_res.pfn1, tlbr_res.c1, tlbr_res.d1, tlbr_res.v1,
			tlbr_res.G};
	end
	if (tlbp_req)
		regs_d.index = tlbp_res;

	if (except_req.valid && except_req.eret) begin
		if (regs_q.status.erl)
			regs_d.status.erl = 1'b0;
		else
			regs_d.status.exl = 1'b0;
	end else if (except_req.valid) begin
		// nested exception keeps the first epc
		if (!regs_q.status.exl) begin
			regs_d.epc      = except_req.delayslot ? except_req.pc - 32'd4 : except_req.pc;
			regs_d.cause.bd = except_req.delayslot;
		end
		regs_d.status.exl     = 1'b1;
		regs_d.cause.exc_code = except_req.code;
		if (except_req.code == EXCCODE_INT)
			regs_d.cause.ip = except_req.extra[7:0];
		if (except_req.code == EXCCODE_ADEL || except_req.code == EXCCODE_ADES)
			regs_d.bad_vaddr = except_req.extra;
		if (except_req.code == EXCCODE_TLBL || except_req.code == EXCCODE_TLBS) begin
			regs_d.bad_vaddr          = except_req.extra;
			regs_d.context_reg[22:4]  = except_req.extra[31:13];
			regs_d.entry_hi[31:13]    = except_req.extra[31:13];
		end
	end
end

endmodule

// File: src/tlb_request_ctrl.sv
`timescale 1ns/1ps

module tlb_request_ctrl #(
	parameter int TLB_ENTRIES = 16
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           tlb_valid,
	input  cpu_pkg::tlb_op_t               tlb_op,
	input  cpu_pkg::tlb_entry_t            tlb_wdata,
	input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_index,
	input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_random,
	output cpu_pkg::vpn2_t                 lookup_vpn2,
	output cpu_pkg::asid_t                 lookup_asid,
	output logic [$clog2(TLB_ENTRIES)-1:0] read_index,
	output logic [TLB_ENTRIES-1:0]         entry_we,
	output cpu_pkg::tlb_entry_t            wdata,
	output logic                           probe_valid,
	output logic                           read_valid,
	output logic                           tlbwr_req
);

import cpu_pkg::*;

localparam int IDX_W = $clog2(TLB_ENTRIES);
localparam logic [TLB_ENTRIES-1:0] ONE_HOT_0 = 1;

logic [IDX_W-1:0] target;
logic             is_write;

assign is_write = tlb_valid && (tlb_op == TLB_OP_WI || tlb_op == TLB_OP_WR);
assign target   = (tlb_op == TLB_OP_WR) ? tlb_random : tlb_index;

always_ff @(posedge clk) begin
	if (rst) begin
		entry_we    <= '0;
		probe_valid <= 1'b0;
		read_valid  <= 1'b0;
		tlbwr_req   <= 1'b0;
	end else begin
		entry_we    <= is_write ? ONE_HOT_0 << target : '0;
		probe_valid <= tlb_valid && tlb_op == TLB_OP_P;
		read_valid  <= tlb_valid && tlb_op == TLB_OP_R;
		tlbwr_req   <= tlb_valid && tlb_op == TLB_OP_WR;
	end
end

// entry data doubles as the probe key
always_ff @(posedge clk) begin
	if (tlb_valid) begin
		wdata      <= tlb_wdata;
		read_index <= tlb_index;
	end
end

assign lookup_vpn2 = wdata.vpn2;
assign lookup_asid = wdata.asid;

endmodule

// File: src/tlb_entry_slot.sv
`timescale 1ns/1ps

module tlb_entry_slot (
	input  logic                clk,
	input  logic                rst,
	input  logic                we,
	input  cpu_pkg::tlb_entry_t wdata,
	input  cpu_pkg::vpn2_t      lookup_vpn2,
	input  cpu_pkg::asid_t      lookup_asid,
	output logic                hit,
	output cpu_pkg::tlb_entry_t entry
);

// only the valid bits come out of reset known
always_ff @(posedge clk) begin
	if (rst) begin
		entry.v0 <= 1'b0;
		entry.v1 <= 1'b0;
	end else if (we) begin
		entry <= wdata;
	end
end

// global pages ignore the asid
assign hit = entry.vpn2 == lookup_vpn2 && (entry.G || entry.asid == lookup_asid);

endmodule

// File: src/tlb_result_collect.sv
`timescale 1ns/1ps

module tlb_result_collect #(
	parameter int TLB_ENTRIES = 16
) (
	input  logic                                      clk,
	input  logic                                      rst,
	input  logic                                      probe_valid,
	input  logic                                      read_valid,
	input  logic [$clog2(TLB_ENTRIES)-1:0]            read_index,
	input  logic [TLB_ENTRIES-1:0]                    hits,
	input  cpu_pkg::tlb_entry_t [TLB_ENTRIES-1:0]     entries,
	output logic                                      tlbp_req,
	output cpu_pkg::uint32_t                          tlbp_res,
	output logic                                      tlbr_req,
	output cpu_pkg::tlb_entry_t                       tlbr_res
);

import cpu_pkg::*;

localparam int IDX_W = $clog2(TLB_ENTRIES);

logic [IDX_W-1:0] hit_index;
logic             found;
uint32_t          probe_word;

// scan from the top so the lowest hit is the one left
always_comb begin
	hit_index = '0;
	found     = 1'b0;
	for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
		if (hits[i]) begin
			hit_index = IDX_W'(i);
			found     = 1'b1;
		end
	end
end

// bit 31 is the probe failure flag
assign probe_word = {~found, {(31 - IDX_W){1'b0}}, hit_index};

always_ff @(posedge clk) begin
	if (rst) begin
		tlbp_req <= 1'b0;
		tlbr_req <= 1'b0;
	end else begin
		tlbp_req <= probe_valid;
		tlbr_req <= read_valid;
	end
end

always_ff @(posedge clk) begin
	if (probe_valid)
		tlbp_res <= probe_word;
	if (read_valid)
		tlbr_res <= entries[read_index];
end

endmodule

// File: src/mmu_top.sv
`timescale 1ns/1ps

module mmu_top #(
	parameter int TLB_ENTRIES = 16,
	parameter bit FULL_CP0    = 1'b1
) (
	input  logic                 clk,
	input  logic                 rst,
	input  cpu_pkg::reg_addr_t   raddr,
	input  logic [2:0]           rsel,
	input  cpu_pkg::cp0_req_t    wreq,
	input  cpu_pkg::except_req_t except_req,
	input  logic                 tlb_valid,
	input  cpu_pkg::tlb_op_t     tlb_op,
	output cpu_pkg::uint32_t     rdata,
	output cpu_pkg::asid_t       asid,
	output logic                 user_mode,
	output logic                 kseg0_uncached,
	output logic                 timer_int
);

import cpu_pkg::*;

localparam int IDX_W = $clog2(TLB_ENTRIES);

tlb_entry_t                   tlb_wdata;
logic [IDX_W-1:0]             tlb_index;
logic [IDX_W-1:0]             tlb_random;
logic [IDX_W-1:0]             read_index;
vpn2_t                        lookup_vpn2;
asid_t                        lookup_asid;
logic [TLB_ENTRIES-1:0]       entry_we;
logic [TLB_ENTRIES-1:0]       hits;
tlb_entry_t                   slot_wdata;
tlb_entry_t [TLB_ENTRIES-1:0] entries;
logic                         probe_valid;
logic                         read_valid;
logic                         tlbwr_req;
logic                         tlbp_req;
uint32_t                      tlbp_res;
logic                         tlbr_req;
tlb_entry_t                   tlbr_res;

cp0 #(
	.TLB_ENTRIES(TLB_ENTRIES),
	.FULL_CP0   (FULL_CP0)
) u_cp0 (
	.clk           (clk),
	.rst           (rst),
	.raddr         (raddr),
	.rsel          (rsel),
	.wreq          (wreq),
	.except_req    (except_req),
	.tlbp_req      (tlbp_req),
	.tlbp_res      (tlbp_res),
	.tlbr_req      (tlbr_req),
	.tlbr_res      (tlbr_res),
	.tlbwr_req     (tlbwr_req),
	.rdata         (rdata),
	.tlb_wdata     (tlb_wdata),
	.tlb_index     (tlb_index),
	.tlb_random    (tlb_random),
	.asid          (asid),
	.user_mode     (user_mode),
	.kseg0_uncached(kseg0_uncached),
	.timer_int     (timer_int)
);

tlb_request_ctrl #(
	.TLB_ENTRIES(TLB_ENTRIES)
) u_request_ctrl (
	.clk        (clk),
	.rst        (rst),
	.tlb_valid  (tlb_valid),
	.tlb_op     (tlb_op),
	.tlb_wdata  (tlb_wdata),
	.tlb_index  (tlb_index),
	.tlb_random (tlb_random),
	.lookup_vpn2(lookup_vpn2),
	.lookup_asid(lookup_asid),
	.read_index (read_index),
	.entry_we   (entry_we),
	.wdata      (slot_wdata),
	.probe_valid(probe_valid),
	.read_valid (read_valid),
	.tlbwr_req  (tlbwr_req)
);

for (genvar i = 0; i < TLB_ENTRIES; i++) begin : gen_slot
	tlb_entry_slot u_slot (
		.clk        (clk),
		.rst        (rst),
		.we         (entry_we[i]),
		.wdata      (slot_wdata),
		.lookup_vpn2(lookup_vpn2),
		.lookup_asid(lookup_asid),
		.hit        (hits[i]),
		.entry      (entries[i])
	);
end

tlb_result_collect #(
	.TLB_ENTRIES(TLB_ENTRIES)
) u_result_collect (
	.clk        (clk),
	.rst        (rst),
	.probe_valid(probe_valid),
	.read_valid (read_valid),
	.read_index (read_index),
	.hits       (hits),
	.entries    (entries),
	.tlbp_req   (tlbp_req),
	.tlbp_res   (tlbp_res),
	.tlbr_req   (tlbr_req),
	.tlbr_res   (tlbr_res)
);

endmodule

// File: dv/mmu_top_tb.sv
`timescale 1ns/1ps

module mmu_top_tb;

import cpu_pkg::*;

localparam int K_WRITE = 0;
localparam int K_READ  = 1;
localparam int K_TLB   = 2;
localparam int K_EXC   = 3;
localparam int K_PINS  = 4;
localparam int K_ARM   = 5;
localparam int K_WAIT  = 6;

localparam reg_addr_t REG_INDEX    = 5'd0;
localparam reg_addr_t REG_RANDOM   = 5'd1;
localparam reg_addr_t REG_LO0      = 5'd2;
localparam reg_addr_t REG_LO1      = 5'd3;
localparam reg_addr_t REG_CONTEXT  = 5'd4;
localparam reg_addr_t REG_WIRED    = 5'd6;
localparam reg_addr_t REG_BADVADDR = 5'd8;
localparam reg_addr_t REG_COUNT    = 5'd9;
localparam reg_addr_t REG_HI       = 5'd10;
localparam reg_addr_t REG_COMPARE  = 5'd11;
localparam reg_addr_t REG_STATUS   = 5'd12;
localparam reg_addr_t REG_CAUSE    = 5'd13;
localparam reg_addr_t REG_EPC      = 5'd14;
localparam reg_addr_t REG_PRID     = 5'd15;
localparam reg_addr_t REG_CONFIG   = 5'd16;

localparam uint32_t ALL        = 32'hffff_ffff;
localparam uint32_t LFSR_SEED  = 32'hca60fa76;
localparam uint32_t LFSR_TAPS  = 32'h8020_0003;
localparam uint32_t PROBE_MISS = 32'h8000_0000;

typedef struct {
	int         kind;
	reg_addr_t  addr;
	logic [2:0] sel;
	uint32_t    data;
	uint32_t    extra;
	uint32_t    exp_val;
	uint32_t    mask;
} row_t;

logic        clk;
logic        rst;
reg_addr_t   raddr;
logic [2:0]  rsel;
cp0_req_t    wreq;
except_req_t except_req;
logic        tlb_valid;
tlb_op_t     tlb_op;
uint32_t     rdata;
asid_t       asid;
logic        user_mode;
logic        kseg0_uncached;
logic        timer_int;

row_t    rows[$];
uint32_t lfsr_state;
// expected TLB contents as entry_hi, entry_lo0 and entry_lo1 words
uint32_t model_hi [16];
uint32_t model_lo0 [16];
uint32_t model_lo1 [16];

mmu_top #(
	.TLB_ENTRIES(16),
	.FULL_CP0   (1'b1)
) uut (
	.clk           (clk),
	.rst           (rst),
	.raddr         (raddr),
	.rsel          (rsel),
	.wreq          (wreq),
	.except_req    (except_req),
	.tlb_valid     (tlb_valid),
	.tlb_op        (tlb_op),
	.rdata         (rdata),
	.asid          (asid),
	.user_mode     (user_mode),
	.kseg0_uncached(kseg0_uncached),
	.timer_int     (timer_int)
);

initial begin
	clk = 1'b0;
	forever #10 clk = ~clk;
end

// galois lfsr stepped once per bit taken
function automatic uint32_t rand_bits(input int n);
	uint32_t v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ LFSR_TAPS : lfsr_state >> 1;
		v = {v[30:0], lfsr_state[0]};
	end
	return v;
endfunction

function automatic uint32_t writable(input int a);
	case (a)
		0, 6:      return 32'h0000_000f;
		2, 3:      return 32'h3fff_ffff;
		4:         return 32'hff80_0000;
		9, 11, 14: return 32'hffff_ffff;
		10:        return 32'hffff_e0ff;
		12:        return 32'h1040_ff17;
		13:        return 32'h0000_0300;
		16:        return 32'h0000_0007;
		default:   return 32'h0;
	endcase
endfunction

// read-only contents that survive a write
function automatic uint32_t fixed_bits(input int a);
	case (a)
		1:       return 32'd15;
		15:      return PRID_VALUE;
		16:      return 32'h8000_0080;
		default: return 32'h0;
	endcase
endfunction

task automatic check(input uint32_t actual, input uint32_t expected, input string what);
	if (actual !== expected) begin
		$display("error at %0t ns: %s read %h, expected %h", $time, what, actual, expected);
		$display("test failed");
		$fatal(1, "stopped at the first mismatch");
	end
endtask

task automatic abort_run(input string why);
	$display("%s", why);
	$display("test failed");
	$fatal(1, "stopped on a timeout");
endtask

task automatic add_row(input int kind, input reg_addr_t addr, input logic [2:0] sel,
		input uint32_t data, input uint32_t extra, input uint32_t exp_val, input uint32_t mask);
	row_t r;
	r.kind    = kind;
	r.addr    = addr;
	r.sel     = sel;
	r.data    = data;
	r.extra   = extra;
	r.exp_val = exp_val;
	r.mask    = mask;
	rows.push_back(r);
endtask

task automatic reg_write(input reg_addr_t addr, input uint32_t data);
	add_row(K_WRITE, addr, 3'd0, data, '0, '0, '0);
endtask

task automatic reg_expect(input reg_addr_t addr, input logic [2:0] sel, input uint32_t exp_val,
		input uint32_t mask);
	add_row(K_READ, addr, sel, '0, '0, exp_val, mask);
endtask

task automatic tlb_instr(input tlb_op_t op);
	add_row(K_TLB, '0, 3'd0, uint32_t'(op), '0, '0, '0);
endtask

task automatic exc_entry(input exc_code_t code, input logic delayslot, input logic eret,
		input uint32_t pc, input uint32_t extra);
	add_row(K_EXC, code, {1'b0, eret, delayslot}, pc, extra, '0, '0);
endtask

// bits 15:8 asid, bit 2 timer_int, bit 1 kseg0_uncached, bit 0 user_mode
task automatic pins_expect(input uint32_t exp_val, input uint32_t mask);
	add_row(K_PINS, '0, 3'd0, '0, '0, exp_val, mask);
endtask

task automatic new_entry(input logic vpn_top, input logic g0, input logic g1, input int slot,
		output uint32_t hi, output uint32_t lo0, output uint32_t lo1);
	uint32_t vpn;
	uint32_t asid_v;
	logic    g;
	vpn    = rand_bits(18);
	asid_v = rand_bits(8);
	hi     = {vpn_top, vpn[17:0], 5'b0, asid_v[7:0]};
	// pfn, c, d, v take 29 bits above the g bit
	lo0    = (rand_bits(29) << 1) | uint32_t'(g0);
	lo1    = (rand_bits(29) << 1) | uint32_t'(g1);
	g      = g0 & g1;
	model_hi[slot]  = hi;
	model_lo0[slot] = {lo0[31:1], g};
	model_lo1[slot] = {lo1[31:1], g};
endtask

task automatic program_slot(input logic vpn_top, input logic g0, input logic g1,
		input int slot);
	uint32_t hi;
	uint32_t lo0;
	uint32_t lo1;
	new_entry(vpn_top, g0, g1, slot, hi, lo0, lo1);
	reg_write(REG_HI, hi);
	reg_write(REG_LO0, lo0);
	reg_write(REG_LO1, lo1);
	reg_write(REG_INDEX, uint32_t'(slot));
	tlb_instr(TLB_OP_WI);
endtask

task automatic probe_expect(input uint32_t hi, input uint32_t exp_index);
	reg_write(REG_HI, hi);
	tlb_instr(TLB_OP_P);
	reg_expect(REG_INDEX, 3'd0, exp_index, ALL);
endtask

task automatic reset_rows();
	reg_expect(REG_STATUS, 3'd0, 32'h0040_0000, ALL);
	reg_expect(REG_CONFIG, 3'd0, 32'h8000_0083, ALL);
	reg_expect(REG_PRID, 3'd0, PRID_VALUE, ALL);
	reg_expect(5'd15, 3'd1, 32'h8000_0000, ALL);
	// config1 mmu size field sits at 30:25
	reg_expect(5'd16, 3'd1, 32'h1e00_0000, 32'hfe00_0000);
	reg_expect(REG_RANDOM, 3'd0, 32'd15, ALL);
	pins_expect(32'd0, 32'd7);
endtask

task automatic masked_write_rows();
	uint32_t data;
	for (int a = 0; a <= 16; a++) begin
		reg_write(reg_addr_t'(a), ALL);
		reg_expect(reg_addr_t'(a), 3'd0, (ALL & writable(a)) | fixed_bits(a), ALL);
		data = rand_bits(32);
		reg_write(reg_addr_t'(a), data);
		reg_expect(reg_addr_t'(a), 3'd0, (data & writable(a)) | fixed_bits(a), ALL);
	end
	add_row(K_WRITE, 5'd15, 3'd1, ALL, '0, '0, '0);
	reg_expect(5'd15, 3'd1, 32'hbfff_f000, ALL);
	reg_write(REG_STATUS, 32'h0000_0010);
	pins_expect(32'd1, 32'd1);
	reg_write(REG_STATUS, 32'h0040_0000);
	pins_expect(32'd0, 32'd1);
	reg_write(REG_CONFIG, 32'd2);
	pins_expect(32'd2, 32'd2);
	reg_write(REG_CONFIG, 32'd3);
	pins_expect(32'd0, 32'd2);
endtask

task automatic tlb_rows();
	int rd_slots [3];
	rd_slots = '{7, 5, 12};
	// fill every slot with a vpn2 from the upper half
	for (int i = 0; i < 16; i++)
		program_slot(1'b1, 1'b0, 1'b0, i);
	program_slot(1'b0, 1'b0, 1'b0, 3);
	program_slot(1'b0, 1'b1, 1'b0, 7);
	program_slot(1'b0, 1'b0, 1'b0, 12);
	program_slot(1'b0, 1'b1, 1'b1, 5);
	probe_expect(model_hi[3], 32'd3);
	probe_expect(model_hi[7], 32'd7);
	probe_expect(model_hi[12], 32'd12);
	probe_expect(model_hi[3] ^ 32'h0000_2000, PROBE_MISS);
	probe_expect(model_hi[7] ^ 32'h0000_00ff, PROBE_MISS);
	probe_expect(model_hi[5] ^ 32'h0000_005a, 32'd5);
	foreach (rd_slots[k]) begin
		reg_write(REG_INDEX, uint32_t'(rd_slots[k]));
		reg_write(REG_LO0, 32'd0);
		reg_write(REG_LO1, 32'd0);
		reg_write(REG_HI, 32'd0);
		tlb_instr(TLB_OP_R);
		reg_expect(REG_HI, 3'd0, model_hi[rd_slots[k]], ALL);
		reg_expect(REG_LO0, 3'd0, model_lo0[rd_slots[k]], ALL);
		reg_expect(REG_LO1, 3'd0, model_lo1[rd_slots[k]], ALL);
		pins_expect((model_hi[rd_slots[k]] & 32'h0000_00ff) << 8, 32'h0000_ff00);
	end
endtask

task automatic random_rows();
	uint32_t hi;
	uint32_t lo0;
	uint32_t lo1;
	int      rnd;
	int      slot;
	reg_write(REG_WIRED, 32'd13);
	reg_expect(REG_RANDOM, 3'd0, 32'd15, ALL);
	rnd = 15;
	for (int k = 0; k < 3; k++) begin
		slot = rnd;
		new_entry(1'b0, 1'b0, 1'b0, slot, hi, lo0, lo1);
		reg_write(REG_HI, hi);
		reg_write(REG_LO0, lo0);
		reg_write(REG_LO1, lo1);
		tlb_instr(TLB_OP_WR);
		rnd = (rnd == 13) ? 15 : rnd - 1;
		reg_expect(REG_RANDOM, 3'd0, uint32_t'(rnd), ALL);
		probe_expect(model_hi[slot], uint32_t'(slot));
	end
endtask

task automatic exception_rows();
	uint32_t pc1;
	uint32_t pc2;
	uint32_t va;
	pc1 = rand_bits(32) & ~32'd3;
	va  = rand_bits(32);
	exc_entry(EXCCODE_ADEL, 1'b1, 1'b0, pc1, va);
	reg_expect(REG_EPC, 3'd0, pc1 - 32'd4, ALL);
	reg_expect(REG_CAUSE, 3'd0, 32'h8000_0000 | (32'd4 << 2), 32'h8000_007c);
	reg_expect(REG_STATUS, 3'd0, 32'd2, 32'd2);
	reg_expect(REG_BADVADDR, 3'd0, va, ALL);
	// nested exception keeps epc and bd
	pc2 = rand_bits(32) & ~32'd3;
	va  = rand_bits(32);
	exc_entry(EXCCODE_ADES, 1'b0, 1'b0, pc2, va);
	reg_expect(REG_EPC, 3'd0, pc1 - 32'd4, ALL);
	reg_expect(REG_CAUSE, 3'd0, 32'h8000_0000 | (32'd5 << 2), 32'h8000_007c);
	reg_expect(REG_BADVADDR, 3'd0, va, ALL);
	exc_entry(5'd0, 1'b0, 1'b1, '0, '0);
	reg_expect(REG_STATUS, 3'd0, 32'd0, 32'd2);
	pc2 = rand_bits(32) & ~32'd3;
	va  = rand_bits(32);
	exc_entry(EXCCODE_TLBL, 1'b0, 1'b0, pc2, va);
	reg_expect(REG_EPC, 3'd0, pc2, ALL);
	reg_expect(REG_CAUSE, 3'd0, 32'd2 << 2, 32'h8000_007c);
	reg_expect(REG_BADVADDR, 3'd0, va, ALL);
	reg_expect(REG_CONTEXT, 3'd0, (va >> 13) << 4, 32'h007f_fff0);
	reg_expect(REG_HI, 3'd0, va, 32'hffff_e000);
	reg_expect(REG_STATUS, 3'd0, 32'd2, 32'd2);
	exc_entry(5'd0, 1'b0, 1'b1, '0, '0);
	reg_expect(REG_STATUS, 3'd0, 32'd0, 32'd2);
	// erl goes first, then exl
	reg_write(REG_STATUS, 32'h0040_0006);
	exc_entry(5'd0, 1'b0, 1'b1, '0, '0);
	reg_expect(REG_STATUS, 3'd0, 32'd2, 32'd6);
	exc_entry(5'd0, 1'b0, 1'b1, '0, '0);
	reg_expect(REG_STATUS, 3'd0, 32'd0, 32'd6);
endtask

task automatic timer_rows();
	add_row(K_ARM, '0, 3'd0, 32'd20, '0, '0, '0);
	pins_expect(32'd0, 32'd4);
	// level 1, at most 100 cycles, not before 15
	add_row(K_WAIT, '0, 3'd0, 32'd1, 32'd100, 32'd15, '0);
	reg_write(REG_COMPARE, 32'd0);
	pins_expect(32'd0, 32'd4);
endtask

// each row starts and ends on a falling edge
task automatic run_row(input int idx, input row_t r);
	string   what;
	uint32_t cnt;
	int      waited;
	what   = $sformatf("row %0d reg %0d sel %0d", idx, r.addr, r.sel);
	waited = 0;
	case (r.kind)
		K_WRITE: begin
			wreq.we    = 1'b1;
			wreq.wsel  = r.sel;
			wreq.waddr = r.addr;
			wreq.wdata = r.data;
			@(negedge clk);
			wreq = '0;
		end
		K_READ: begin
			raddr = r.addr;
			rsel  = r.sel;
			#2;
			check(rdata & r.mask, r.exp_val & r.mask, what);
			@(negedge clk);
		end
		K_TLB: begin
			tlb_valid = 1'b1;
			tlb_op    = tlb_op_t'(r.data[1:0]);
			@(negedge clk);
			tlb_valid = 1'b0;
			// result lands in cp0 two edges later, plus one spare cycle
			repeat (3) @(negedge clk);
		end
		K_EXC: begin
			except_req.valid     = 1'b1;
			except_req.eret      = r.sel[1];
			except_req.delayslot = r.sel[0];
			except_req.code      = r.addr;
			except_req.pc        = r.data;
			except_req.extra     = r.extra;
			@(negedge clk);
			except_req = '0;
		end
		K_PINS: begin
			#2;
			check({16'd0, asid, 5'd0, timer_int, kseg0_uncached, user_mode} & r.mask,
				r.exp_val & r.mask, $sformatf("row %0d output pins", idx));
			@(negedge clk);
		end
		K_ARM: begin
			raddr = REG_COUNT;
			rsel  = 3'd0;
			#2;
			cnt = rdata;
			@(negedge clk);
			wreq.we    = 1'b1;
			wreq.wsel  = 3'd0;
			wreq.waddr = REG_COMPARE;
			wreq.wdata = cnt + r.data;
			@(negedge clk);
			wreq = '0;
		end
		K_WAIT: begin
			while (timer_int !== r.data[0]) begin
				if (waited >= int'(r.extra))
					abort_run($sformatf("timeout: timer_int did not rise in %0d cycles", waited));
				@(negedge clk);
				waited++;
			end
			check(uint32_t'(waited >= int'(r.exp_val)), 32'd1,
				$sformatf("row %0d timer_int raised early", idx));
		end
		default: abort_run($sformatf("row %0d has an unknown kind", idx));
	endcase
endtask

initial begin
	rst        = 1'b1;
	raddr      = '0;
	rsel       = '0;
	wreq       = '0;
	except_req = '0;
	tlb_valid  = 1'b0;
	tlb_op     = TLB_OP_P;
	lfsr_state = LFSR_SEED;
	reset_rows();
	masked_write_rows();
	tlb_rows();
	random_rows();
	exception_rows();
	timer_rows();
	repeat (2) @(negedge clk);
	rst = 1'b0;
	foreach (rows[i])
		run_row(i, rows[i]);
	$display("test passed");
	$finish;
end

endmodule

// File: verilog.f
src/cpu_pkg.sv
src/cp0_write_mask.sv
src/cp0.sv
src/tlb_request_ctrl.sv
src/tlb_entry_slot.sv
src/tlb_result_collect.sv
src/mmu_top.sv
dv/mmu_top_tb.sv
